// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_huff17
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= TEST OK

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
huff17_pkg.sv
huff17_codebook.sv
huff_code_capture.sv
pair_field_reader.sv
huff17_pair_decoder.sv
huff17_checker.sv
tb_huff17.sv

// ==== huff17_checker.sv ====
`default_nettype none

module huff17_checker import huff17_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         bit_valid,
	input  logic         pair_valid,
	input  sample_pair_t pair,
	input  logic         code_error,
	input  logic         code_error_ok,
	input  logic         exp_push,
	input  mag_t         exp_x_mag,
	input  mag_t         exp_y_mag,
	input  lin_t         exp_x_lin,
	input  lin_t         exp_y_lin,
	input  logic         exp_x_sign,
	input  logic         exp_y_sign,
	output int           pair_count,
	output int           error_count,
	output int           code_error_count
);

	timeunit 1ns;
	timeprecision 1ps;

	sample_pair_t expected_q[$];
	logic taken_d;

	// magnitude plus linbits when escaped, negated for a set sign bit
	function automatic sample_t expected_value(mag_t mag, lin_t lin, logic sign);
		int v;
		v = int'(mag);
		if (v == escape_mag)
			v = v + int'(lin);
		if (sign)
			v = -v;
		return sample_t'(v);
	endfunction

	function automatic sample_pair_t expected_pair(mag_t xm, mag_t ym, lin_t xl, lin_t yl,
			logic xs, logic ys);
		sample_pair_t p;
		p.x = expected_value(xm, xl, xs);
		p.y = expected_value(ym, yl, ys);
		return p;
	endfunction

	always @(posedge clk) begin : compare
		int errs;
		sample_pair_t want;
		errs = 0;
		if (rst) begin
			expected_q.delete();
			taken_d = 1'b0;
			pair_count <= 0;
			error_count <= 0;
			code_error_count <= 0;
		end else begin
			if (exp_push)
				expected_q.push_back(expected_pair(exp_x_mag, exp_y_mag, exp_x_lin, exp_y_lin,
					exp_x_sign, exp_y_sign));
			if (pair_valid && code_error) begin
				$display("pair_valid and code_error are high in the same cycle");
				errs++;
			end
			if (pair_valid) begin
				// every output must follow a bit that was taken one edge earlier
				if (!taken_d) begin
					$display("pair_valid rose in a cycle that follows no taken bit");
					errs++;
				end
				if (expected_q.size() == 0) begin
					$display("pair_valid with no pair expected, got x 0x%04h y 0x%04h",
						pair.x, pair.y);
					errs++;
				end else begin
					want = expected_q.pop_front();
					if (pair.x !== want.x) begin
						$display("[FAIL] pair.x expected 0x%04h got 0x%04h", want.x, pair.x);
						errs++;
					end
					if (pair.y !== want.y) begin
						$display("[FAIL] pair.y expected 0x%04h got 0x%04h", want.y, pair.y);
						errs++;
					end
				end
			end
			if (code_error && !code_error_ok) begin
				$display("code_error raised while only valid codewords were sent");
				errs++;
			end
			pair_count <= pair_count + (pair_valid ? 1 : 0);
			code_error_count <= code_error_count + (code_error ? 1 : 0);
			error_count <= error_count + errs;
			taken_d = bit_valid;
		end
	end

endmodule

`default_nettype wire

// ==== huff17_codebook.sv ====
`default_nettype none

module huff17_codebook import huff17_pkg::*; (
	input  code_bits_t  code_bits,
	input  code_len_t   code_len,
	output code_match_t match
);

	function automatic code_match_t hit(mag_t x, mag_t y);
		code_match_t m;
		m.found = 1'b1;
		m.x_mag = x;
		m.y_mag = y;
		return m;
	endfunction

	// only the leading code_len bits are valid, the rest may hold an older code
	always_comb begin
		match = '0;
		case (code_len)
			4'd1: begin
				if (code_bits[max_code_len-1])
					match = hit(4'd0, 4'd0);
			end
			4'd3: begin
				if (code_bits[max_code_len-1 -: 3] == 3'b011)
					match = hit(4'd1, 4'd0);
			end
			4'd4: begin
				case (code_bits[max_code_len-1 -: 4])
					4'b0101: match = hit(4'd0, 4'd1);
					4'b0100: match = hit(4'd1, 4'd1);
					default: match = '0;
				endcase
			end
			4'd6: begin
				case (code_bits[max_code_len-1 -: 6])
					6'b001110: match = hit(4'd0, 4'd2);
					6'b001100: match = hit(4'd1, 4'd2);
					6'b001111: match = hit(4'd2, 4'd0);
					6'b001101: match = hit(4'd2, 4'd1);
					default:   match = '0;
				endcase
			end
			4'd7: begin
				case (code_bits[max_code_len-1 -: 7])
					7'b0010100: match = hit(4'd1, 4'd3);
					7'b0010111: match = hit(4'd2, 4'd2);
					7'b0010101: match = hit(4'd3, 4'd1);
					default:    match = '0;
				endcase
			end
			4'd8: begin
				case (code_bits[max_code_len-1 -: 8])
					8'b00101100: match = hit(4'd0, 4'd3);
					8'b00100011: match = hit(4'd1, 4'd4);
					8'b00001001: match = hit(4'd1, 4'd15);
					8'b00100110: match = hit(4'd2, 4'd3);
					8'b00101101: match = hit(4'd3, 4'd0);
					8'b00100111: match = hit(4'd3, 4'd2);
					8'b00100100: match = hit(4'd4, 4'd1);
					8'b00011110: match = hit(4'd5, 4'd1);
					8'b00001010: match = hit(4'd15, 4'd1);
					8'b00000111: match = hit(4'd15, 4'd2);
					8'b00000011: match = hit(4'd15, 4'd15);
					default:     match = '0;
				endcase
			end
			4'd9: begin
				case (code_bits[max_code_len-1 -: 9])
					9'b001001010: match = hit(4'd0, 4'd4);
					9'b000111111: match = hit(4'd0, 4'd5);
					9'b000010001: match = hit(4'd0, 4'd15);
					9'b000111110: match = hit(4'd1, 4'd5);
					9'b000110101: match = hit(4'd1, 4'd6);
					9'b000101111: match = hit(4'd1, 4'd7);
					9'b001000011: match = hit(4'd2, 4'd4);
					9'b000111010: match = hit(4'd2, 4'd5);
					9'b000010000: match = hit(4'd2, 4'd15);
					9'b001000101: match = hit(4'd3, 4'd3);
					9'b001000000: match = hit(4'd3, 4'd4);
					9'b001001011: match = hit(4'd4, 4'd0);
					9'b001000100: match = hit(4'd4, 4'd2);
					9'b001000001: match = hit(4'd4, 4'd3);
					9'b000001001: match = hit(4'd4, 4'd15);
					9'b001000010: match = hit(4'd5, 4'd0);
					9'b000111011: match = hit(4'd5, 4'd2);
					9'b000111000: match = hit(4'd5, 4'd3);
					9'b000110110: match = hit(4'd6, 4'd1);
					9'b000110100: match = hit(4'd6, 4'd2);
					9'b000110000: match = hit(4'd7, 4'd1);
					9'b000001100: match = hit(4'd15, 4'd0);
					9'b000001011: match = hit(4'd15, 4'd3);
					9'b000001010: match = hit(4'd15, 4'd4);
					default:      match = '0;
				endcase
			end
			// no codeword of length 0, 2 or 5 in this table
			default: match = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== huff17_pair_decoder.sv ====
`default_nettype none

module huff17_pair_decoder import huff17_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         bit_valid,
	input  logic         bit_data,
	output logic         pair_valid,
	output sample_pair_t pair,
	output logic         code_error
);

	code_bits_t code_bits;
	code_len_t code_len;
	code_match_t match;
	logic field_busy;

	huff_code_capture huff_code_capture_i (
		.clk        (clk),
		.rst        (rst),
		.bit_valid  (bit_valid),
		.bit_data   (bit_data),
		.field_busy (field_busy),
		.match      (match),
		.code_bits  (code_bits),
		.code_len   (code_len),
		.code_error (code_error)
	);

	huff17_codebook huff17_codebook_i (
		.code_bits (code_bits),
		.code_len  (code_len),
		.match     (match)
	);

	// linbits and sign bits go here instead of the capture while busy
	pair_field_reader pair_field_reader_i (
		.clk        (clk),
		.rst        (rst),
		.bit_valid  (bit_valid),
		.bit_data   (bit_data),
		.match      (match),
		.field_busy (field_busy),
		.pair_valid (pair_valid),
		.pair       (pair)
	);

endmodule

`default_nettype wire

// ==== huff17_pkg.sv ====
`default_nettype none

package huff17_pkg;

	// longest codeword kept from table 17
	localparam int max_code_len = 9;

	// table 17 carries two linbits on every escaped coordinate
	localparam int linbits = 2;
	localparam int escape_mag = 15;

	// first received code bit sits in the msb
	typedef logic [max_code_len-1:0] code_bits_t;
	typedef logic [3:0] code_len_t;
	typedef logic [3:0] mag_t;
	typedef logic [linbits-1:0] lin_t;
	typedef logic signed [15:0] sample_t;

	typedef struct packed {
		logic found;
		mag_t x_mag;
		mag_t y_mag;
	} code_match_t;

	typedef struct packed {
		sample_t x;
		sample_t y;
	} sample_pair_t;

	typedef enum logic [2:0] {
		st_code,
		st_x_lin,
		st_x_sign,
		st_y_lin,
		st_y_sign,
		st_done
	} field_state_t;

endpackage

`default_nettype wire

// ==== huff_code_capture.sv ====
`default_nettype none

module huff_code_capture import huff17_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        bit_valid,
	input  logic        bit_data,
	input  logic        field_busy,
	input  code_match_t match,
	output code_bits_t  code_bits,
	output code_len_t   code_len,
	output logic        code_error
);

	logic take;
	logic restart;

	// bits belong to the field reader while it is busy
	assign take = bit_valid && !field_busy;

	// a full-length code that still matches nothing is not in the kept table
	assign code_error = (code_len == code_len_t'(max_code_len)) && !match.found;

	assign restart = match.found || code_error;

	always_ff @(posedge clk) begin
		if (rst) begin
			code_len <= '0;
		end else if (restart) begin
			code_len <= take ? code_len_t'(1) : code_len_t'(0);
		end else if (take) begin
			code_len <= code_len + 1'b1;
		end
	end

	// stale low bits are harmless, the codebook only looks at the top code_len bits
	always_ff @(posedge clk) begin
		if (take) begin
			if (restart)
				code_bits[max_code_len-1] <= bit_data;
			else
				code_bits[max_code_len-1-int'(code_len)] <= bit_data;
		end
	end

endmodule

`default_nettype wire

// ==== pair_field_reader.sv ====
`default_nettype none

module pair_field_reader import huff17_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         bit_valid,
	input  logic         bit_data,
	input  code_match_t  match,
	output logic         field_busy,
	output logic         pair_valid,
	output sample_pair_t pair
);

	field_state_t state;
	field_state_t cur;
	logic [1:0] lin_cnt;
	mag_t x_mag_q;
	mag_t y_mag_q;
	mag_t x_eff;
	mag_t y_eff;
	lin_t x_lin;
	lin_t y_lin;
	logic x_sign;
	logic y_sign;

	// first field still needed after position s, in stream order
	function automatic field_state_t next_field(field_state_t s, mag_t xm, mag_t ym);
		field_state_t n;
		n = st_done;
		if (s == st_code && xm == mag_t'(escape_mag))
			n = st_x_lin;
		else if ((s == st_code || s == st_x_lin) && xm != '0)
			n = st_x_sign;
		else if (s != st_y_lin && s != st_y_sign && ym == mag_t'(escape_mag))
			n = st_y_lin;
		else if (s != st_y_sign && ym != '0)
			n = st_y_sign;
		return n;
	endfunction

	function automatic sample_t form_sample(mag_t m, lin_t l, logic s);
		sample_t v;
		v = sample_t'(m);
		if (m == mag_t'(escape_mag))
			v = v + sample_t'(l);
		return s ? -v : v;
	endfunction

	// the match shows up the cycle after the last code bit, so that cycle already
	// behaves as the first field state (or as done for a zero pair)
	assign cur = (state == st_code && match.found) ?
		next_field(st_code, match.x_mag, match.y_mag) : state;

	assign x_eff = (state == st_code) ? match.x_mag : x_mag_q;
	assign y_eff = (state == st_code) ? match.y_mag : y_mag_q;

	assign field_busy = (cur == st_x_lin) || (cur == st_x_sign) ||
		(cur == st_y_lin) || (cur == st_y_sign);
	assign pair_valid = (cur == st_done);

	assign pair.x = form_sample(x_eff, x_lin, x_sign);
	assign pair.y = form_sample(y_eff, y_lin, y_sign);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_code;
			lin_cnt <= '0;
		end else if (cur == st_done) begin
			state <= st_code;
		end else if (bit_valid && field_busy) begin
			case (cur)
				st_x_lin, st_y_lin: begin
					if (lin_cnt == 2'(linbits - 1)) begin
						lin_cnt <= '0;
						state <= next_field(cur, x_eff, y_eff);
					end else begin
						lin_cnt <= lin_cnt + 1'b1;
						state <= cur;
					end
				end
				default: state <= next_field(cur, x_eff, y_eff);
			endcase
		end else begin
			state <= cur;
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_code && match.found) begin
			x_mag_q <= match.x_mag;
			y_mag_q <= match.y_mag;
		end
		if (bit_valid) begin
			case (cur)
				st_x_lin:  x_lin <= {x_lin[linbits-2:0], bit_data};
				st_x_sign: x_sign <= bit_data;
				st_y_lin:  y_lin <= {y_lin[linbits-2:0], bit_data};
				st_y_sign: y_sign <= bit_data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb_huff17.sv ====
`default_nettype none

module tb_huff17 import huff17_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_codes = 46;
	localparam int esc_mag = 15;
	localparam int lin_len = 2;
	localparam int stream_len = 200;
	localparam int random_pairs = 64;

	// each entry is {length, 3'b0, code right-aligned in 9 bits, x, y} in hex
	localparam logic [23:0] code_table [num_codes] = '{
		24'h100100, 24'h300310, 24'h400501, 24'h400411, 24'h600e02, 24'h600c12,
		24'h600f20, 24'h600d21, 24'h701413, 24'h701722, 24'h701531, 24'h802c03,
		24'h802314, 24'h80091f, 24'h802623, 24'h802d30, 24'h802732, 24'h802441,
		24'h801e51, 24'h800af1, 24'h8007f2, 24'h8003ff, 24'h904a04, 24'h903f05,
		24'h90110f, 24'h903e15, 24'h903516, 24'h902f17, 24'h904324, 24'h903a25,
		24'h90102f, 24'h904533, 24'h904034, 24'h904b40, 24'h904442, 24'h904143,
		24'h90094f, 24'h904250, 24'h903b52, 24'h903853, 24'h903661, 24'h903462,
		24'h903071, 24'h900cf0, 24'h900bf3, 24'h900af4
	};

	logic clk;
	logic rst;
	logic bit_valid;
	logic bit_data;
	logic pair_valid;
	sample_pair_t pair;
	logic code_error;

	logic code_error_ok;
	logic exp_push;
	mag_t exp_x_mag;
	mag_t exp_y_mag;
	lin_t exp_x_lin;
	lin_t exp_y_lin;
	logic exp_x_sign;
	logic exp_y_sign;
	int pair_count;
	int error_count;
	int code_error_count;

	int tb_errors;
	int tests_passed;
	int tests_failed;
	int base_errors;
	int base_pairs;

	// the back-to-back stream is kept so the gapped run can replay it
	int s_idx [stream_len];
	lin_t s_xl [stream_len];
	lin_t s_yl [stream_len];
	logic s_xs [stream_len];
	logic s_ys [stream_len];

	initial clk = 1'b0;
	always #10 clk = ~clk;

	huff17_pair_decoder huff17_pair_decoder_i (
		.clk        (clk),
		.rst        (rst),
		.bit_valid  (bit_valid),
		.bit_data   (bit_data),
		.pair_valid (pair_valid),
		.pair       (pair),
		.code_error (code_error)
	);

	huff17_checker huff17_checker_i (
		.clk              (clk),
		.rst              (rst),
		.bit_valid        (bit_valid),
		.pair_valid       (pair_valid),
		.pair             (pair),
		.code_error       (code_error),
		.code_error_ok    (code_error_ok),
		.exp_push         (exp_push),
		.exp_x_mag        (exp_x_mag),
		.exp_y_mag        (exp_y_mag),
		.exp_x_lin        (exp_x_lin),
		.exp_y_lin        (exp_y_lin),
		.exp_x_sign       (exp_x_sign),
		.exp_y_sign       (exp_y_sign),
		.pair_count       (pair_count),
		.error_count      (error_count),
		.code_error_count (code_error_count)
	);

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			bit_valid <= 1'b0;
			exp_push <= 1'b0;
		end
	endtask

	task automatic drive_bit(input logic b, input bit gaps);
		int idle;
		idle = 0;
		if (gaps && $urandom_range(0, 3) == 0)
			idle = int'($urandom_range(1, 3));
		idle_cycles(idle);
		@(posedge clk);
		bit_valid <= 1'b1;
		bit_data <= b;
		exp_push <= 1'b0;
	endtask

	// code bits first, then x linbits and sign, then y linbits and sign
	task automatic send_pair(input int idx, input lin_t xl, input lin_t yl,
			input logic xs, input logic ys, input bit gaps);
		logic [23:0] e;
		int len;
		int x;
		int y;
		logic bits[$];
		e = code_table[idx];
		len = int'(e[23:20]);
		x = int'(e[7:4]);
		y = int'(e[3:0]);
		for (int i = len - 1; i >= 0; i--)
			bits.push_back(e[8 + i]);
		if (x == esc_mag)
			for (int i = lin_len - 1; i >= 0; i--)
				bits.push_back(xl[i]);
		if (x != 0)
			bits.push_back(xs);
		if (y == esc_mag)
			for (int i = lin_len - 1; i >= 0; i--)
				bits.push_back(yl[i]);
		if (y != 0)
			bits.push_back(ys);
		for (int i = 0; i < bits.size(); i++) begin
			drive_bit(bits[i], gaps);
			if (i == 0) begin
				exp_push <= 1'b1;
				exp_x_mag <= mag_t'(x);
				exp_y_mag <= mag_t'(y);
				exp_x_lin <= (x == esc_mag) ? xl : '0;
				exp_y_lin <= (y == esc_mag) ? yl : '0;
				exp_x_sign <= (x != 0) ? xs : 1'b0;
				exp_y_sign <= (y != 0) ? ys : 1'b0;
			end
		end
	endtask

	task automatic pick_random(output int idx, output lin_t xl, output lin_t yl,
			output logic xs, output logic ys);
		idx = int'($urandom_range(0, num_codes - 1));
		xl = lin_t'($urandom_range(0, 3));
		yl = lin_t'($urandom_range(0, 3));
		xs = 1'($urandom_range(0, 1));
		ys = 1'($urandom_range(0, 1));
	endtask

	task automatic start_test();
		base_errors = error_count + tb_errors;
		base_pairs = pair_count;
	endtask

	task automatic finish_test(input int num, input string name, input int want);
		int cycles;
		int errs;
		idle_cycles(1);
		cycles = 0;
		while (pair_count < base_pairs + want && cycles < 100) begin
			@(posedge clk);
			cycles++;
		end
		if (pair_count < base_pairs + want)
			$display("timeout in test %0d: only %0d of %0d pairs came out",
				num, pair_count - base_pairs, want);
		idle_cycles(4);
		if (pair_count != base_pairs + want) begin
			$display("test %0d saw %0d pairs instead of %0d", num, pair_count - base_pairs, want);
			tb_errors++;
		end
		errs = error_count + tb_errors - base_errors;
		if (errs == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("test %0d %s: %0d pairs, %0d errors", num, name, pair_count - base_pairs, errs);
	endtask

	initial begin : run
		int idx;
		lin_t xl;
		lin_t yl;
		logic xs;
		logic ys;
		int ce_base;
		int cycles;
		void'($urandom(66));
		rst = 1'b1;
		bit_valid = 1'b0;
		bit_data = 1'b0;
		code_error_ok = 1'b0;
		exp_push = 1'b0;
		exp_x_mag = '0;
		exp_y_mag = '0;
		exp_x_lin = '0;
		exp_y_lin = '0;
		exp_x_sign = 1'b0;
		exp_y_sign = 1'b0;
		tb_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		idle_cycles(2);

		start_test();
		for (int i = 0; i < num_codes; i++)
			send_pair(i, '0, '0, 1'b0, 1'b0, 1'b0);
		finish_test(1, "every codeword", num_codes);

		start_test();
		for (int i = 0; i < random_pairs; i++) begin
			pick_random(idx, xl, yl, xs, ys);
			send_pair(idx, xl, yl, xs, ys, 1'b0);
			idle_cycles(2);
		end
		finish_test(2, "signs and linbits", random_pairs);

		start_test();
		for (int i = 0; i < stream_len; i++) begin
			pick_random(s_idx[i], s_xl[i], s_yl[i], s_xs[i], s_ys[i]);
			send_pair(s_idx[i], s_xl[i], s_yl[i], s_xs[i], s_ys[i], 1'b0);
		end
		finish_test(3, "back-to-back stream", stream_len);

		start_test();
		for (int i = 0; i < stream_len; i++)
			send_pair(s_idx[i], s_xl[i], s_yl[i], s_xs[i], s_ys[i], 1'b1);
		finish_test(4, "gaps in the input", stream_len);

		// nine zeros are no codeword of the kept table
		start_test();
		ce_base = code_error_count;
		code_error_ok <= 1'b1;
		repeat (max_code_len) drive_bit(1'b0, 1'b0);
		idle_cycles(1);
		cycles = 0;
		while (code_error_count == ce_base && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		idle_cycles(2);
		if (code_error_count != ce_base + 1) begin
			$display("code_error pulsed %0d times after nine unknown bits",
				code_error_count - ce_base);
			tb_errors++;
		end
		code_error_ok <= 1'b0;
		send_pair(21, 2'd3, 2'd2, 1'b1, 1'b0, 1'b0);
		finish_test(5, "unknown code", 1);

		// idle outputs right after reset count as well
		idle_cycles(1);
		$display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count + tb_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
